//--- verilog/pit_pkg.sv
// ============================================================================
// programmable interval timer, shared definitions
// ============================================================================
package pit_pkg;

	// channel count and datapath widths
	localparam int pit_n_timers = 4;
	localparam int pit_cnt_w = 32;
	localparam int pit_data_w = 64;
	localparam int pit_adr_w = 12;

	// register index is the 64-bit word address, adr[11:3]
	localparam int pit_reg_idx_w = pit_adr_w - 3;
	// channel number sits in adr[11:5], four words per channel
	localparam int pit_chan_num_w = pit_adr_w - 5;
	localparam int pit_chan_idx_w = $clog2(pit_n_timers);

	// per-channel slot, adr[4:3]
	typedef enum logic [1:0] {
		pit_reg_count = 2'd0,
		pit_reg_max = 2'd1,
		pit_reg_ont = 2'd2,
		pit_reg_ctrl = 2'd3
	} pit_chan_reg_e;

	// global registers live above the channel space
	typedef enum logic [pit_reg_idx_w-1:0] {
		pit_reg_underflow = 9'h100,
		pit_reg_sync = 9'h101,
		pit_reg_ie = 9'h102,
		pit_reg_temp = 9'h103,
		pit_reg_out = 9'h104,
		pit_reg_igate = 9'h105,
		pit_reg_igate_set = 9'h106,
		pit_reg_igate_clr = 9'h107
	} pit_glob_reg_e;

	// control word bit positions
	localparam int pit_ctrl_ld = 0;
	localparam int pit_ctrl_ce = 1;
	localparam int pit_ctrl_ar = 2;
	localparam int pit_ctrl_xc = 3;
	localparam int pit_ctrl_ge = 4;
	// commit only exists in write data, it is never stored
	localparam int pit_ctrl_commit = 7;
	localparam int pit_ctrl_w = 5;

	// out of reset only auto-reload is set
	localparam logic [pit_ctrl_w-1:0] pit_ctrl_rst = 5'b0_0100;

endpackage

//--- verilog/pit_ext_sync.sv
`timescale 1ns/1ns

module pit_ext_sync (
	input  logic                            clk_i,
	input  logic                            rst_i,
	input  logic [pit_pkg::pit_n_timers-1:0] ext_clk_i,
	input  logic [pit_pkg::pit_n_timers-1:0] gate_i,
	output logic [pit_pkg::pit_n_timers-1:0] ext_tick_o,
	output logic [pit_pkg::pit_n_timers-1:0] gate_o
);
	import pit_pkg::*;

	// two-stage synchronizers for the external clocks
	logic [pit_n_timers-1:0] clk_s1;
	logic [pit_n_timers-1:0] clk_s2;
	// previous synchronized level, for the edge compare
	logic [pit_n_timers-1:0] clk_s3;
	logic [pit_n_timers-1:0] tick_q;
	// gate pins only need the synchronizer
	logic [pit_n_timers-1:0] gate_s1;
	logic [pit_n_timers-1:0] gate_s2;

	// ========================================================================
	// synchronizers and registered rising edge detect
	// ========================================================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			clk_s1 <= '0;
			clk_s2 <= '0;
			clk_s3 <= '0;
			tick_q <= '0;
			gate_s1 <= '0;
			gate_s2 <= '0;
		end else begin
			clk_s1 <= ext_clk_i;
			clk_s2 <= clk_s1;
			clk_s3 <= clk_s2;
			// one pulse per low-to-high transition, three edges after the pin
			tick_q <= clk_s2 & ~clk_s3;
			gate_s1 <= gate_i;
			gate_s2 <= gate_s1;
		end
	end

	assign ext_tick_o = tick_q;
	// gates are levels, passed on as synchronized
	assign gate_o = gate_s2;

endmodule

//--- verilog/pit_reg_file.sv
`timescale 1ns/1ns

module pit_reg_file (
	input  logic                                                   clk_i,
	input  logic                                                   rst_i,
	// peripheral bus
	input  logic                                                   cs_i,
	input  logic                                                   we_i,
	input  logic [pit_pkg::pit_adr_w-1:0]                          adr_i,
	input  logic [pit_pkg::pit_data_w-1:0]                         dat_i,
	output logic                                                   ack_o,
	output logic [pit_pkg::pit_data_w-1:0]                         dat_o,
	// readback from the channels and the interrupt block
	input  logic [pit_pkg::pit_n_timers-1:0][pit_pkg::pit_cnt_w-1:0]  count_i,
	input  logic [pit_pkg::pit_n_timers-1:0][pit_pkg::pit_ctrl_w-1:0] ctrl_act_i,
	input  logic [pit_pkg::pit_n_timers-1:0][pit_pkg::pit_cnt_w-1:0]  max_act_i,
	input  logic [pit_pkg::pit_n_timers-1:0][pit_pkg::pit_cnt_w-1:0]  ont_act_i,
	input  logic [pit_pkg::pit_n_timers-1:0]                       out_i,
	input  logic [pit_pkg::pit_n_timers-1:0]                       underflow_i,
	input  logic [pit_pkg::pit_n_timers-1:0]                       ie_i,
	// holding values and strobes to the channels
	output logic [pit_pkg::pit_n_timers-1:0]                       commit_o,
	output logic [pit_pkg::pit_n_timers-1:0][pit_pkg::pit_ctrl_w-1:0] ctrl_o,
	output logic [pit_pkg::pit_n_timers-1:0][pit_pkg::pit_cnt_w-1:0]  max_o,
	output logic [pit_pkg::pit_n_timers-1:0][pit_pkg::pit_cnt_w-1:0]  ont_o,
	output logic [pit_pkg::pit_n_timers-1:0]                       igate_o,
	output logic                                                   ie_wr_o,
	output logic                                                   uf_clr_o
);
	import pit_pkg::*;

	logic wr;
	logic rd;
	logic rd_done_q;
	logic [pit_reg_idx_w-1:0] reg_idx;
	logic [pit_chan_num_w-1:0] chan_num;
	logic [pit_chan_idx_w-1:0] chan;
	logic chan_hit;
	logic glob_hit;
	pit_chan_reg_e slot;
	pit_glob_reg_e glob;
	logic [pit_n_timers-1:0] ctrl_wr;
	logic [pit_n_timers-1:0] max_wr;
	logic [pit_n_timers-1:0] ont_wr;
	logic [pit_n_timers-1:0] sync_sel;
	logic [pit_n_timers-1:0][pit_ctrl_w-1:0] ctrl_h;
	logic [pit_n_timers-1:0][pit_cnt_w-1:0] max_h;
	logic [pit_n_timers-1:0][pit_cnt_w-1:0] ont_h;
	logic [pit_n_timers-1:0] igate_q;
	logic [pit_data_w-1:0] temp_q;
	logic [pit_data_w-1:0] rd_mux;

	// ========================================================================
	// address decode
	// ========================================================================
	assign wr = cs_i && we_i;
	assign rd = cs_i && !we_i;
	assign reg_idx = adr_i[pit_adr_w-1:3];
	assign chan_num = adr_i[pit_adr_w-1:5];
	assign chan = chan_num[pit_chan_idx_w-1:0];
	assign slot = pit_chan_reg_e'(adr_i[4:3]);
	assign glob = pit_glob_reg_e'(reg_idx);
	assign chan_hit = chan_num < pit_chan_num_w'(pit_n_timers);
	// top index bit splits channel space from global space
	assign glob_hit = reg_idx[pit_reg_idx_w-1];

	always_comb begin
		for (int i = 0; i < pit_n_timers; i++) begin
			ctrl_wr[i] = wr && chan_num == pit_chan_num_w'(i) && slot == pit_reg_ctrl;
			max_wr[i] = wr && chan_num == pit_chan_num_w'(i) && slot == pit_reg_max;
			ont_wr[i] = wr && chan_num == pit_chan_num_w'(i) && slot == pit_reg_ont;
		end
	end

	// sync register data picks which channels commit together
	assign sync_sel = (wr && glob == pit_reg_sync) ? dat_i[pit_n_timers-1:0] : '0;

	// commit either from a control write with bit 7 or from the sync register
	always_comb begin
		for (int i = 0; i < pit_n_timers; i++) begin
			commit_o[i] = (ctrl_wr[i] && dat_i[pit_ctrl_commit]) || sync_sel[i];
			// a committing control write hands its own data straight through
			ctrl_o[i] = ctrl_wr[i] ? dat_i[pit_ctrl_w-1:0] : ctrl_h[i];
		end
	end

	assign max_o = max_h;
	assign ont_o = ont_h;
	assign igate_o = igate_q;
	assign ie_wr_o = wr && glob == pit_reg_ie;
	assign uf_clr_o = wr && glob == pit_reg_underflow;

	// ========================================================================
	// holding registers, internal gate
	// ========================================================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int i = 0; i < pit_n_timers; i++) begin
				ctrl_h[i] <= pit_ctrl_rst;
			end
			igate_q <= '0;
		end else begin
			for (int i = 0; i < pit_n_timers; i++) begin
				if (ctrl_wr[i]) begin
					ctrl_h[i] <= dat_i[pit_ctrl_w-1:0];
				end else if (sync_sel[i]) begin
					// a load fires once per sync, not on every later sync
					ctrl_h[i][pit_ctrl_ld] <= 1'b0;
				end
			end
			if (wr) begin
				case (glob)
					pit_reg_igate: igate_q <= dat_i[pit_n_timers-1:0];
					pit_reg_igate_set: igate_q <= igate_q | dat_i[pit_n_timers-1:0];
					pit_reg_igate_clr: igate_q <= igate_q & ~dat_i[pit_n_timers-1:0];
					default: igate_q <= igate_q;
				endcase
			end
		end
	end

	// max, on time and temp are plain data words
	always_ff @(posedge clk_i) begin
		for (int i = 0; i < pit_n_timers; i++) begin
			if (max_wr[i]) begin
				max_h[i] <= dat_i[pit_cnt_w-1:0];
			end
			if (ont_wr[i]) begin
				ont_h[i] <= dat_i[pit_cnt_w-1:0];
			end
		end
		if (wr && glob == pit_reg_temp) begin
			temp_q <= dat_i;
		end
	end

	// ========================================================================
	// read mux and acknowledge
	// ========================================================================
	always_comb begin
		rd_mux = '0;
		if (glob_hit) begin
			case (glob)
				pit_reg_underflow: rd_mux = pit_data_w'(underflow_i);
				pit_reg_ie: rd_mux = pit_data_w'(ie_i);
				pit_reg_temp: rd_mux = temp_q;
				pit_reg_out: rd_mux = pit_data_w'(out_i);
				pit_reg_igate: rd_mux = pit_data_w'(igate_q);
				// sync and the gate aliases are write only
				default: rd_mux = '0;
			endcase
		end else if (chan_hit) begin
			case (slot)
				pit_reg_count: rd_mux = pit_data_w'(count_i[chan]);
				pit_reg_max: rd_mux = pit_data_w'(max_act_i[chan]);
				pit_reg_ont: rd_mux = pit_data_w'(ont_act_i[chan]);
				// load flag is transient, always reads as zero
				default: rd_mux = pit_data_w'({ctrl_act_i[chan][pit_ctrl_w-1:1], 1'b0});
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rd_done_q <= 1'b0;
			dat_o <= '0;
		end else begin
			// toggles so back-to-back reads each get a fresh wait cycle
			rd_done_q <= rd && !rd_done_q;
			dat_o <= rd ? rd_mux : '0;
		end
	end

	// writes ack at once, reads one cycle later
	assign ack_o = cs_i && (we_i || rd_done_q);

endmodule

//--- verilog/pit_channel.sv
`timescale 1ns/1ns

module pit_channel (
	input  logic                           clk_i,
	input  logic                           rst_i,
	input  logic                           commit_i,
	input  logic [pit_pkg::pit_ctrl_w-1:0] ctrl_i,
	input  logic [pit_pkg::pit_cnt_w-1:0]  max_i,
	input  logic [pit_pkg::pit_cnt_w-1:0]  ont_i,
	input  logic                           ext_tick_i,
	input  logic                           gate_i,
	input  logic                           igate_i,
	output logic [pit_pkg::pit_cnt_w-1:0]  count_o,
	output logic [pit_pkg::pit_ctrl_w-1:0] ctrl_act_o,
	output logic [pit_pkg::pit_cnt_w-1:0]  max_act_o,
	output logic [pit_pkg::pit_cnt_w-1:0]  ont_act_o,
	output logic                           out_o,
	output logic                           underflow_o
);
	import pit_pkg::*;

	// active control, bit 0 doubles as the one-cycle load flag
	logic [pit_ctrl_w-1:0] ctrl_q;
	logic [pit_cnt_w-1:0] max_q;
	logic [pit_cnt_w-1:0] ont_q;
	logic [pit_cnt_w-1:0] count_q;
	logic out_q;
	logic uf_q;
	logic tick;
	logic match;
	logic tc;

	// count enable: ce, clock source select, optional gating
	assign tick = ctrl_q[pit_ctrl_ce]
		&& (!ctrl_q[pit_ctrl_xc] || ext_tick_i)
		&& (!ctrl_q[pit_ctrl_ge] || (igate_i && gate_i));
	assign match = count_q == ont_q;
	// terminal count, on-time match takes priority
	assign tc = tick && !ctrl_q[pit_ctrl_ld] && !match && count_q == '0;

	// ========================================================================
	// active copies of the holding registers
	// ========================================================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ctrl_q <= pit_ctrl_rst;
			max_q <= '0;
			ont_q <= '0;
		end else if (commit_i) begin
			ctrl_q <= ctrl_i;
			max_q <= max_i;
			ont_q <= ont_i;
		end else begin
			ctrl_q[pit_ctrl_ld] <= 1'b0;
			// one-shot stops itself at terminal count
			if (tc && !ctrl_q[pit_ctrl_ar]) begin
				ctrl_q[pit_ctrl_ce] <= 1'b0;
			end
		end
	end

	// ========================================================================
	// down counter, output pin, underflow pulse
	// ========================================================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			count_q <= '0;
			out_q <= 1'b0;
			uf_q <= 1'b0;
		end else begin
			uf_q <= tc;
			if (ctrl_q[pit_ctrl_ld]) begin
				count_q <= max_q;
			end else if (tick) begin
				count_q <= count_q - 1'b1;
				if (match) begin
					out_q <= 1'b1;
				end else if (tc) begin
					out_q <= 1'b0;
					// without reload the count is left wrapped at all ones
					if (ctrl_q[pit_ctrl_ar]) begin
						count_q <= max_q;
					end
				end
			end
		end
	end

	assign count_o = count_q;
	assign ctrl_act_o = ctrl_q;
	assign max_act_o = max_q;
	assign ont_act_o = ont_q;
	assign out_o = out_q;
	assign underflow_o = uf_q;

endmodule

//--- verilog/pit_irq_status.sv
`timescale 1ns/1ns

module pit_irq_status (
	input  logic                            clk_i,
	input  logic                            rst_i,
	input  logic [pit_pkg::pit_n_timers-1:0] uf_pulse_i,
	input  logic                            ie_wr_i,
	input  logic                            uf_clr_i,
	input  logic [pit_pkg::pit_n_timers-1:0] wr_data_i,
	output logic [pit_pkg::pit_n_timers-1:0] underflow_o,
	output logic [pit_pkg::pit_n_timers-1:0] ie_o,
	output logic                            irq_o
);
	import pit_pkg::*;

	logic [pit_n_timers-1:0] uf_q;
	logic [pit_n_timers-1:0] ie_q;
	logic [pit_n_timers-1:0] irqf_q;
	// bits to drop on a write to the underflow register
	logic [pit_n_timers-1:0] clr;
	logic irq_q;

	assign clr = uf_clr_i ? wr_data_i : '0;

	// ========================================================================
	// underflow latches, enables, interrupt flags
	// ========================================================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			uf_q <= '0;
			ie_q <= '0;
			irqf_q <= '0;
			irq_q <= 1'b0;
		end else begin
			// a new underflow wins over a clear in the same cycle
			uf_q <= (uf_q & ~clr) | uf_pulse_i;
			irqf_q <= (irqf_q & ~clr) | (uf_pulse_i & ie_q);
			// acknowledging an underflow also disables its interrupt
			if (ie_wr_i) begin
				ie_q <= wr_data_i;
			end else begin
				ie_q <= ie_q & ~clr;
			end
			// combined line, one cycle behind the flags
			irq_q <= |irqf_q;
		end
	end

	assign underflow_o = uf_q;
	assign ie_o = ie_q;
	assign irq_o = irq_q;

endmodule

//--- verilog/pit_top.sv
`timescale 1ns/1ns

module pit_top (
	input  logic                            clk_i,
	input  logic                            rst_i,
	input  logic                            cs_i,
	input  logic                            we_i,
	input  logic [pit_pkg::pit_adr_w-1:0]    adr_i,
	input  logic [pit_pkg::pit_data_w-1:0]   dat_i,
	output logic                            ack_o,
	output logic [pit_pkg::pit_data_w-1:0]   dat_o,
	input  logic [pit_pkg::pit_n_timers-1:0] ext_clk_i,
	input  logic [pit_pkg::pit_n_timers-1:0] gate_i,
	output logic [pit_pkg::pit_n_timers-1:0] out_o,
	output logic                            irq_o
);
	import pit_pkg::*;

	// synchronized external inputs
	logic [pit_n_timers-1:0] ext_tick;
	logic [pit_n_timers-1:0] gate;
	// register file to channels
	logic [pit_n_timers-1:0] commit;
	logic [pit_n_timers-1:0][pit_ctrl_w-1:0] ctrl;
	logic [pit_n_timers-1:0][pit_cnt_w-1:0] max;
	logic [pit_n_timers-1:0][pit_cnt_w-1:0] ont;
	logic [pit_n_timers-1:0] igate;
	// channel readback
	logic [pit_n_timers-1:0][pit_cnt_w-1:0] count;
	logic [pit_n_timers-1:0][pit_ctrl_w-1:0] ctrl_act;
	logic [pit_n_timers-1:0][pit_cnt_w-1:0] max_act;
	logic [pit_n_timers-1:0][pit_cnt_w-1:0] ont_act;
	logic [pit_n_timers-1:0] uf_pulse;
	// interrupt block
	logic [pit_n_timers-1:0] underflow;
	logic [pit_n_timers-1:0] ie;
	logic ie_wr;
	logic uf_clr;

	pit_ext_sync u_ext_sync (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.ext_clk_i  (ext_clk_i),
		.gate_i     (gate_i),
		.ext_tick_o (ext_tick),
		.gate_o     (gate)
	);

	pit_reg_file u_reg_file (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.cs_i        (cs_i),
		.we_i        (we_i),
		.adr_i       (adr_i),
		.dat_i       (dat_i),
		.ack_o       (ack_o),
		.dat_o       (dat_o),
		.count_i     (count),
		.ctrl_act_i  (ctrl_act),
		.max_act_i   (max_act),
		.ont_act_i   (ont_act),
		.out_i       (out_o),
		.underflow_i (underflow),
		.ie_i        (ie),
		.commit_o    (commit),
		.ctrl_o      (ctrl),
		.max_o       (max),
		.ont_o       (ont),
		.igate_o     (igate),
		.ie_wr_o     (ie_wr),
		.uf_clr_o    (uf_clr)
	);

	// one counter per channel
	for (genvar g = 0; g < pit_n_timers; g++) begin : g_chan
		pit_channel u_channel (
			.clk_i       (clk_i),
			.rst_i       (rst_i),
			.commit_i    (commit[g]),
			.ctrl_i      (ctrl[g]),
			.max_i       (max[g]),
			.ont_i       (ont[g]),
			.ext_tick_i  (ext_tick[g]),
			.gate_i      (gate[g]),
			.igate_i     (igate[g]),
			.count_o     (count[g]),
			.ctrl_act_o  (ctrl_act[g]),
			.max_act_o   (max_act[g]),
			.ont_act_o   (ont_act[g]),
			.out_o       (out_o[g]),
			.underflow_o (uf_pulse[g])
		);
	end

	pit_irq_status u_irq_status (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.uf_pulse_i  (uf_pulse),
		.ie_wr_i     (ie_wr),
		.uf_clr_i    (uf_clr),
		.wr_data_i   (dat_i[pit_n_timers-1:0]),
		.underflow_o (underflow),
		.ie_o        (ie),
		.irq_o       (irq_o)
	);

endmodule

//--- tests/pit_tb_util.svh
`ifndef PIT_TB_UTIL_SVH
`define PIT_TB_UTIL_SVH

// lfsr state, advanced once per random bit drawn
logic [31:0] lfsr_q = 32'haa1d;

// ============================================================================
// random bits, error exit, compare
// ============================================================================
// fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] r;
	logic fb;
	r = '0;
	for (int i = 0; i < n; i++) begin
		fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
		lfsr_q = {lfsr_q[30:0], fb};
		r = {r[30:0], fb};
	end
	return r;
endfunction

task automatic stop_failed(input string why);
	$display("%s", why);
	$display("Errors found");
	$fatal(1, "simulation stopped");
endtask

task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] expv);
	if (got !== expv) begin
		stop_failed($sformatf("mismatch at %0t ns: %s is 0x%0h, expected 0x%0h",
			$time, name, got, expv));
	end
endtask

// expected {out, count} after k ticks from a fresh load of max_v
function automatic logic [32:0] ref_after_ticks(input logic [31:0] max_v,
	input logic [31:0] ont_v, input logic ar_v, input int k);
	logic [31:0] cnt;
	logic out_v;
	logic run;
	cnt = max_v;
	out_v = 1'b0;
	run = 1'b1;
	for (int i = 0; i < k; i++) begin
		if (run) begin
			// on-time match wins over terminal count
			if (cnt == ont_v) begin
				out_v = 1'b1;
				cnt = cnt - 32'd1;
			end else if (cnt == 32'd0) begin
				out_v = 1'b0;
				if (ar_v) begin
					cnt = max_v;
				end else begin
					// one-shot wraps to all ones and stops
					cnt = '1;
					run = 1'b0;
				end
			end else begin
				cnt = cnt - 32'd1;
			end
		end
	end
	return {out_v, cnt};
endfunction

`endif

//--- tests/pit_tb.sv
`timescale 1ns/1ns

module pit_tb;

	localparam int clk_period = 40;
	// test lengths in clock cycles, for the watchdog
	localparam int len_reset = 20;
	localparam int len_regs = 80;
	localparam int len_one_shot = 100;
	localparam int len_ext = 130;
	localparam int len_gate = 70;
	localparam int len_irq = 80;
	localparam int wd_cycles = len_reset + len_regs + len_one_shot + len_ext
		+ len_gate + len_irq + 100;

	// register map, word index times 8
	localparam int slot_count = 0;
	localparam int slot_max = 1;
	localparam int slot_ont = 2;
	localparam int slot_ctrl = 3;
	localparam logic [11:0] adr_uf = 12'h800;
	localparam logic [11:0] adr_sync = 12'h808;
	localparam logic [11:0] adr_ie = 12'h810;
	localparam logic [11:0] adr_temp = 12'h818;
	localparam logic [11:0] adr_out = 12'h820;
	localparam logic [11:0] adr_igate = 12'h828;
	localparam logic [11:0] adr_igate_set = 12'h830;
	localparam logic [11:0] adr_igate_clr = 12'h838;

	logic clk_i;
	logic rst_i;
	logic cs_i;
	logic we_i;
	logic [11:0] adr_i;
	logic [63:0] dat_i;
	logic ack_o;
	logic [63:0] dat_o;
	logic [3:0] ext_clk_i;
	logic [3:0] gate_i;
	logic [3:0] out_o;
	logic irq_o;

	`include "pit_tb_util.svh"

	pit_top u_pit_top (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.cs_i      (cs_i),
		.we_i      (we_i),
		.adr_i     (adr_i),
		.dat_i     (dat_i),
		.ack_o     (ack_o),
		.dat_o     (dat_o),
		.ext_clk_i (ext_clk_i),
		.gate_i    (gate_i),
		.out_o     (out_o),
		.irq_o     (irq_o)
	);

	always #(clk_period / 2) clk_i = ~clk_i;

	// ========================================================================
	// bus access, driven on the falling edge
	// ========================================================================
	function automatic logic [11:0] chan_adr(input int ch, input int slot);
		return 12'(ch * 32 + slot * 8);
	endfunction

	task automatic idle(input int n);
		repeat (n) @(negedge clk_i);
	endtask

	// ack is checked a little after the falling edge
	task automatic wait_ack();
		int n;
		n = 0;
		#1;
		while (!ack_o) begin
			@(negedge clk_i);
			#1;
			n++;
			if (n > 8) begin
				stop_failed("bus access got no acknowledge");
			end
		end
	endtask

	task automatic bus_write(input logic [11:0] adr, input logic [63:0] dat);
		@(negedge clk_i);
		cs_i = 1'b1;
		we_i = 1'b1;
		adr_i = adr;
		dat_i = dat;
		wait_ack();
		// write lands on the next rising edge
		@(negedge clk_i);
		cs_i = 1'b0;
		we_i = 1'b0;
		dat_i = '0;
	endtask

	task automatic bus_read(input logic [11:0] adr, output logic [63:0] dat);
		@(negedge clk_i);
		cs_i = 1'b1;
		we_i = 1'b0;
		adr_i = adr;
		wait_ack();
		dat = dat_o;
		@(negedge clk_i);
		cs_i = 1'b0;
	endtask

	// ========================================================================
	// test sequences
	// ========================================================================
	task automatic check_reset_state();
		logic [63:0] rd;
		check_val("ack_o after reset", 64'(ack_o), 64'd0);
		check_val("irq_o after reset", 64'(irq_o), 64'd0);
		check_val("out_o after reset", 64'(out_o), 64'd0);
		for (int ch = 0; ch < 4; ch++) begin
			bus_read(chan_adr(ch, slot_ctrl), rd);
			check_val($sformatf("ch%0d ctrl after reset", ch), rd, 64'h4);
			bus_read(chan_adr(ch, slot_count), rd);
			check_val($sformatf("ch%0d count after reset", ch), rd, 64'd0);
		end
	endtask

	task automatic check_registers();
		logic [31:0] a;
		logic [31:0] b;
		logic [63:0] v;
		logic [63:0] rd;
		a = rand_bits(32);
		b = rand_bits(32);
		// holding writes only, active copies stay at reset
		bus_write(chan_adr(1, slot_max), 64'(a));
		bus_write(chan_adr(1, slot_ont), 64'(b));
		bus_read(chan_adr(1, slot_max), rd);
		check_val("ch1 max before commit", rd, 64'd0);
		bus_read(chan_adr(1, slot_ont), rd);
		check_val("ch1 ont before commit", rd, 64'd0);
		// commit with ld ar xc ge, ce off so nothing counts
		bus_write(chan_adr(1, slot_ctrl), 64'h9d);
		bus_read(chan_adr(1, slot_max), rd);
		check_val("ch1 max after commit", rd, 64'(a));
		bus_read(chan_adr(1, slot_ont), rd);
		check_val("ch1 ont after commit", rd, 64'(b));
		bus_read(chan_adr(1, slot_ctrl), rd);
		check_val("ch1 ctrl after commit", rd, 64'h1c);
		bus_read(chan_adr(1, slot_count), rd);
		check_val("ch1 count after load", rd, 64'(a));
		v = 64'(rand_bits(4));
		bus_write(adr_ie, v);
		bus_read(adr_ie, rd);
		check_val("ie", rd, v);
		bus_write(adr_ie, 64'd0);
		// internal gate, direct write then set and clear aliases
		bus_write(adr_igate, 64'h5);
		bus_read(adr_igate, rd);
		check_val("igate write", rd, 64'h5);
		bus_write(adr_igate_set, 64'h2);
		bus_read(adr_igate, rd);
		check_val("igate set alias", rd, 64'h7);
		bus_write(adr_igate_clr, 64'h4);
		bus_read(adr_igate, rd);
		check_val("igate clear alias", rd, 64'h3);
		bus_write(adr_igate, 64'd0);
		v = {rand_bits(32), rand_bits(32)};
		bus_write(adr_temp, v);
		bus_read(adr_temp, rd);
		check_val("temp", rd, v);
	endtask

	task automatic run_one_shot();
		logic [31:0] m;
		logic [31:0] t;
		logic [32:0] expv;
		logic [63:0] rd;
		int n;
		m = 32'd4 + rand_bits(4);
		t = 32'd1 + rand_bits(2);
		bus_write(chan_adr(0, slot_max), 64'(m));
		bus_write(chan_adr(0, slot_ont), 64'(t));
		// commit ld ce, ar clear
		bus_write(chan_adr(0, slot_ctrl), 64'h83);
		n = 0;
		rd = '0;
		while (!rd[0]) begin
			bus_read(adr_uf, rd);
			n++;
			if (n > 20) begin
				stop_failed("one-shot channel 0 never reached underflow");
			end
		end
		// m+1 ticks reach terminal count, the rest are ignored
		expv = ref_after_ticks(m, t, 1'b0, int'(m) + 4);
		bus_read(chan_adr(0, slot_count), rd);
		check_val("ch0 count after one-shot", rd, 64'(expv[31:0]));
		bus_read(chan_adr(0, slot_ctrl), rd);
		check_val("ch0 ctrl after one-shot", rd, 64'd0);
		bus_read(adr_out, rd);
		check_val("ch0 out after one-shot", 64'(rd[0]), 64'(expv[32]));
		bus_write(adr_uf, 64'h1);
	endtask

	task automatic run_ext_clock();
		logic [31:0] m [2];
		logic [31:0] t [2];
		logic [32:0] expv [2];
		logic [63:0] rd;
		int k;
		for (int ch = 0; ch < 2; ch++) begin
			m[ch] = 32'd16 + rand_bits(5);
			t[ch] = rand_bits(5);
			bus_write(chan_adr(ch, slot_max), 64'(m[ch]));
			bus_write(chan_adr(ch, slot_ont), 64'(t[ch]));
			// ld ce ar xc held back, commit bit clear
			bus_write(chan_adr(ch, slot_ctrl), 64'h0f);
		end
		k = 1 + int'(rand_bits(3));
		// both channels go live on the same edge
		bus_write(adr_sync, 64'h3);
		idle(2);
		repeat (k) begin
			ext_clk_i[1:0] = 2'b11;
			idle(2);
			ext_clk_i[1:0] = 2'b00;
			idle(4);
		end
		// synchronizer and edge flop, then the count update
		idle(6);
		for (int ch = 0; ch < 2; ch++) begin
			expv[ch] = ref_after_ticks(m[ch], t[ch], 1'b1, k);
			bus_read(chan_adr(ch, slot_count), rd);
			check_val($sformatf("ch%0d count after ext ticks", ch), rd, 64'(expv[ch][31:0]));
		end
		bus_read(adr_out, rd);
		check_val("out register bits 1:0", 64'(rd[1:0]), 64'({expv[1][32], expv[0][32]}));
		check_val("out_o pins 1:0", 64'(out_o[1:0]), 64'({expv[1][32], expv[0][32]}));
	endtask

	task automatic run_gating();
		logic [31:0] m;
		logic [63:0] rd;
		m = 32'd100 + rand_bits(6);
		gate_i[2] = 1'b1;
		bus_write(chan_adr(2, slot_max), 64'(m));
		// on time above max never matches
		bus_write(chan_adr(2, slot_ont), 64'(m + 32'd1));
		bus_write(chan_adr(2, slot_ctrl), 64'h97);
		idle(20);
		bus_read(chan_adr(2, slot_count), rd);
		check_val("ch2 count with igate clear", rd, 64'(m));
		bus_write(adr_igate_set, 64'h4);
		idle(10);
		bus_read(chan_adr(2, slot_count), rd);
		check_val("ch2 count below max", 64'(rd[31:0] < m), 64'd1);
		// park channel 2 through the clear alias
		bus_write(adr_igate_clr, 64'h4);
	endtask

	task automatic run_interrupt();
		logic [31:0] m;
		logic [63:0] rd;
		int n;
		m = 32'd8 + rand_bits(3);
		bus_write(adr_ie, 64'h8);
		bus_write(chan_adr(3, slot_max), 64'(m));
		bus_write(chan_adr(3, slot_ont), 64'd2);
		// commit ld ce ar
		bus_write(chan_adr(3, slot_ctrl), 64'h87);
		n = 0;
		while (!irq_o) begin
			@(negedge clk_i);
			n++;
			if (n > int'(m) + 20) begin
				stop_failed("irq_o never rose after channel 3 underflow");
			end
		end
		bus_read(chan_adr(3, slot_count), rd);
		check_val("ch3 count within max", 64'(rd[31:0] <= m), 64'd1);
		bus_read(adr_uf, rd);
		check_val("underflow bit 3", 64'(rd[3]), 64'd1);
		// halt the channel so no new underflow lands during the clear
		bus_write(chan_adr(3, slot_ctrl), 64'h84);
		bus_write(adr_uf, 64'h8);
		idle(2);
		check_val("irq_o after clear", 64'(irq_o), 64'd0);
		bus_read(adr_uf, rd);
		check_val("underflow bit 3 after clear", 64'(rd[3]), 64'd0);
		bus_read(adr_ie, rd);
		check_val("ie after clear", rd, 64'd0);
	endtask

	// ========================================================================
	// main sequence and watchdog
	// ========================================================================
	initial begin
		clk_i = 1'b0;
		rst_i = 1'b1;
		cs_i = 1'b0;
		we_i = 1'b0;
		adr_i = '0;
		dat_i = '0;
		ext_clk_i = '0;
		gate_i = '0;
		repeat (5) @(negedge clk_i);
		rst_i = 1'b0;
		check_reset_state();
		check_registers();
		run_one_shot();
		run_ext_clock();
		run_gating();
		run_interrupt();
		$display("No errors");
		$finish;
	end

	initial begin
		#(wd_cycles * clk_period);
		stop_failed("timeout, the test sequences did not finish in time");
	end

endmodule

//--- project.f
+incdir+tests
verilog/pit_pkg.sv
verilog/pit_ext_sync.sv
verilog/pit_reg_file.sv
verilog/pit_channel.sv
verilog/pit_irq_status.sv
verilog/pit_top.sv
tests/pit_tb.sv

//--- run_sim.sh
#!/bin/bash
# build the timer testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" \
	&& verilator --binary --timing -Wno-fatal -f project.f --top-module pit_tb \
		--Mdir obj_dir -o pit_sim \
	&& ./obj_dir/pit_sim | tee /dev/stderr | grep -qx "No errors" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
